// ==== src/saturn_bus_settings.svh ====
// ======================================================================
// sizes shared by the bus controller and the devices
//   address nibbles per pointer or base, pointer width
//   window sizes of the I/O register block and the system RAM
// ======================================================================

`ifndef SATURN_BUS_SETTINGS_SVH
`define SATURN_BUS_SETTINGS_SVH

// pointers and bases go out low nibble first
`define SATURN_ADDR_NIBBLES 5
`define SATURN_ADDR_BITS    20

// 64 nibbles of I/O registers
`define SATURN_MMIO_BITS    6

// 256 nibbles of system RAM
`define SATURN_RAM_BITS     8

`endif

// ==== src/saturn_bus_pkg.sv ====
// ======================================================================
// types of the nibble bus
//   bus command nibbles, host operations, controller states
// ======================================================================

`default_nettype none

package saturn_bus_pkg;

    // command nibble codes of the Saturn bus
    typedef enum logic [3:0] {
        NONE      = 4'h0,
        DP_READ   = 4'h1,
        DP_WRITE  = 4'h3,
        LOAD_DP   = 4'h5,
        CONFIGURE = 4'h6,
        RESET     = 4'hf
    } bus_cmd_e;

    typedef enum logic [1:0] {
        OP_CONFIGURE = 2'd0,
        OP_READ      = 2'd1,
        OP_WRITE     = 2'd2
    } host_op_e;

    typedef enum logic [2:0] {
        BOOT,
        IDLE,
        CMD,
        ADDR,
        DATA,
        CAPTURE,
        ACK,
        RELEASE
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/saturn_bus_ctrl.sv ====
// ======================================================================
// bus controller
//   takes one host operation over a four-phase req/ack handshake
//   and plays it out as command and data cycles on the nibble bus,
//   then returns the nibble of whichever device answered a read
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_settings.svh"

module saturn_bus_ctrl (
    input  wire                           i_clk,
    input  wire                           i_reset,
    input  wire                           i_req,
    input  var saturn_bus_pkg::host_op_e  i_op,
    input  wire  [`SATURN_ADDR_BITS-1:0]  i_addr,
    input  wire  [3:0]                    i_wdata,
    output logic                          o_ack,
    output logic [3:0]                    o_rdata,
    output logic                          o_bus_strobe,
    output logic                          o_bus_is_data,
    output logic [3:0]                    o_bus_nibble,
    output logic                          o_daisy,
    input  wire  [3:0]                    i_ram_nibble,
    input  wire                           i_ram_active,
    input  wire  [3:0]                    i_mmio_nibble,
    input  wire                           i_mmio_active
);
    import saturn_bus_pkg::*;

    localparam int unsigned LAST_POS = `SATURN_ADDR_NIBBLES - 1;

    ctrl_state_e                  state;
    host_op_e                     op_q;
    logic [`SATURN_ADDR_BITS-1:0] addr_q;
    logic [3:0]                   wdata_q;
    logic [2:0]                   pos;
    logic                         addr_done;
    logic                         sel_ram;
    logic                         sel_mmio;

    // bus outputs are registered, each state sets up the next cycle
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= BOOT;
            o_ack        <= 1'b0;
            o_bus_strobe <= 1'b0;
            o_daisy      <= 1'b0;
            pos          <= '0;
            addr_done    <= 1'b0;
            sel_ram      <= 1'b0;
            sel_mmio     <= 1'b0;
        end else begin
            o_bus_strobe <= 1'b0;
            case (state)
                BOOT: begin
                    // unconfigure everything, then open the daisy chain
                    o_bus_strobe  <= 1'b1;
                    o_bus_is_data <= 1'b0;
                    o_bus_nibble  <= RESET;
                    o_daisy       <= 1'b1;
                    state         <= IDLE;
                end
                IDLE: begin
                    if (i_req) begin
                        op_q          <= i_op;
                        addr_q        <= i_addr;
                        wdata_q       <= i_wdata;
                        addr_done     <= 1'b0;
                        o_bus_strobe  <= 1'b1;
                        o_bus_is_data <= 1'b0;
                        o_bus_nibble  <= (i_op == OP_CONFIGURE) ? CONFIGURE : LOAD_DP;
                        state         <= CMD;
                    end
                end
                CMD: begin
                    o_bus_strobe  <= 1'b1;
                    o_bus_is_data <= 1'b1;
                    if (addr_done) begin
                        // DP_WRITE is on the bus, the write nibble follows
                        o_bus_nibble <= wdata_q;
                        state        <= DATA;
                    end else begin
                        o_bus_nibble <= addr_q[3:0];
                        pos          <= '0;
                        state        <= ADDR;
                    end
                end
                ADDR: begin
                    if (pos != 3'(LAST_POS)) begin
                        o_bus_strobe  <= 1'b1;
                        o_bus_is_data <= 1'b1;
                        o_bus_nibble  <= addr_q[(pos + 3'd1) * 4 +: 4];
                        pos           <= pos + 3'd1;
                    end else begin
                        addr_done <= 1'b1;
                        case (op_q)
                            OP_READ: begin
                                // devices have switched to DP_READ on their own
                                o_bus_strobe  <= 1'b1;
                                o_bus_is_data <= 1'b1;
                                o_bus_nibble  <= 4'h0;
                                state         <= DATA;
                            end
                            OP_WRITE: begin
                                o_bus_strobe  <= 1'b1;
                                o_bus_is_data <= 1'b0;
                                o_bus_nibble  <= DP_WRITE;
                                state         <= CMD;
                            end
                            default: begin
                                o_ack <= 1'b1;
                                state <= ACK;
                            end
                        endcase
                    end
                end
                DATA: begin
                    sel_ram  <= i_ram_active;
                    sel_mmio <= i_mmio_active;
                    if (op_q == OP_READ) begin
                        state <= CAPTURE;
                    end else begin
                        o_ack <= 1'b1;
                        state <= ACK;
                    end
                end
                CAPTURE: begin
                    // read nibble shows up one clock after the data cycle
                    if (sel_ram) begin
                        o_rdata <= i_ram_nibble;
                    end else if (sel_mmio) begin
                        o_rdata <= i_mmio_nibble;
                    end else begin
                        o_rdata <= 4'h0;
                    end
                    o_ack <= 1'b1;
                    state <= ACK;
                end
                ACK: begin
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= RELEASE;
                    end
                end
                RELEASE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_ack) |-> i_req)
        else $error("ack raised with no request pending");

    // windows are disjoint, so at most one device may claim a cycle
    single_device: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_ram_active && i_mmio_active))
        else $error("both devices active at once");

endmodule

`default_nettype wire

// ==== src/saturn_mmio.sv ====
// ======================================================================
// I/O register block on the nibble bus
//   base address configuration through the daisy chain
//   data pointer tracking and window decode
//   64 nibbles of register storage, menu height and ROM mode decode
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_settings.svh"

module saturn_mmio (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_bus_strobe,
    input  wire        i_bus_is_data,
    input  wire  [3:0] i_bus_nibble,
    input  wire        i_bus_daisy,
    output logic       o_bus_daisy,
    output logic [3:0] o_bus_nibble_out,
    output logic       o_bus_active,
    output logic [5:0] o_menu_height,
    output logic       o_rom_mode
);
    import saturn_bus_pkg::*;

    localparam int unsigned WORDS     = 1 << `SATURN_MMIO_BITS;
    localparam int unsigned LAST_POS  = `SATURN_ADDR_NIBBLES - 1;
    localparam logic [`SATURN_MMIO_BITS-1:0] REG_MENU_LO = 6'h28;
    localparam logic [`SATURN_MMIO_BITS-1:0] REG_MENU_HI = 6'h29;

    logic [3:0]                   regs [WORDS];
    bus_cmd_e                     last_cmd;
    logic [2:0]                   addr_pos;
    logic [`SATURN_ADDR_BITS-1:0] local_dp;
    logic [`SATURN_ADDR_BITS-1:0] dp_next;
    logic [`SATURN_ADDR_BITS-1:0] base_addr;
    logic [`SATURN_ADDR_BITS-1:0] offset;
    logic                         configured;
    logic                         active;
    logic                         last_addr;
    logic                         do_read;
    logic                         do_write;

    function automatic logic in_window(input logic [`SATURN_ADDR_BITS-1:0] ptr);
        in_window = configured && (ptr >= base_addr) && ((ptr - base_addr) < WORDS);
    endfunction

    // pointer value once the incoming address nibble is in place
    always_comb begin
        dp_next = local_dp;
        dp_next[addr_pos * 4 +: 4] = i_bus_nibble;
    end

    assign last_addr    = (addr_pos == 3'(LAST_POS));
    assign offset       = local_dp - base_addr;
    assign do_read      = i_bus_strobe && i_bus_is_data && active && (last_cmd == DP_READ);
    assign do_write     = i_bus_strobe && i_bus_is_data && active && (last_cmd == DP_WRITE);
    assign o_bus_daisy  = configured;
    assign o_bus_active = active;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd   <= NONE;
            addr_pos   <= '0;
            local_dp   <= '0;
            base_addr  <= '0;
            configured <= 1'b0;
            active     <= 1'b0;
        end else if (i_bus_strobe) begin
            if (i_bus_is_data) begin
                case (last_cmd)
                    DP_READ, DP_WRITE: local_dp <= local_dp + 1'b1;
                    LOAD_DP: begin
                        local_dp <= dp_next;
                        addr_pos <= addr_pos + 3'd1;
                        // auto switch, window decoded from the full pointer
                        if (last_addr) begin
                            last_cmd <= DP_READ;
                            active   <= in_window(dp_next);
                        end
                    end
                    CONFIGURE: begin
                        if (i_bus_daisy && !configured) begin
                            base_addr[addr_pos * 4 +: 4] <= i_bus_nibble;
                            addr_pos                     <= addr_pos + 3'd1;
                            if (last_addr) begin
                                configured <= 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end else begin
                last_cmd <= bus_cmd_e'(i_bus_nibble);
                addr_pos <= '0;
                active   <= ((i_bus_nibble == DP_READ) || (i_bus_nibble == DP_WRITE))
                            && in_window(local_dp);
                if (i_bus_nibble == RESET) begin
                    base_addr  <= '0;
                    configured <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_write) begin
            regs[offset[`SATURN_MMIO_BITS-1:0]] <= i_bus_nibble;
        end
        if (do_read) begin
            o_bus_nibble_out <= regs[offset[`SATURN_MMIO_BITS-1:0]];
        end
    end

    // decoded control registers
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_menu_height <= '0;
            o_rom_mode    <= 1'b0;
        end else if (do_write) begin
            case (offset[`SATURN_MMIO_BITS-1:0])
                REG_MENU_LO: o_menu_height[3:0] <= i_bus_nibble;
                REG_MENU_HI: begin
                    // bit 2 of this nibble is only stored
                    o_menu_height[5:4] <= i_bus_nibble[1:0];
                    o_rom_mode         <= i_bus_nibble[3];
                end
                default: ;
            endcase
        end
    end

    regs_need_config: assert property (@(posedge i_clk) disable iff (i_reset)
        !configured |=> ($stable(o_menu_height) && $stable(o_rom_mode)))
        else $error("control register changed while unconfigured");

endmodule

`default_nettype wire

// ==== src/saturn_sysram.sv ====
// ======================================================================
// system RAM on the nibble bus
//   base address configuration, data pointer tracking,
//   window decode and 256 nibbles of storage
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_settings.svh"

module saturn_sysram (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_bus_strobe,
    input  wire        i_bus_is_data,
    input  wire  [3:0] i_bus_nibble,
    input  wire        i_bus_daisy,
    output logic       o_bus_daisy,
    output logic [3:0] o_bus_nibble_out,
    output logic       o_bus_active
);
    import saturn_bus_pkg::*;

    localparam int unsigned WORDS    = 1 << `SATURN_RAM_BITS;
    localparam int unsigned LAST_POS = `SATURN_ADDR_NIBBLES - 1;

    logic [3:0]                   mem [WORDS];
    bus_cmd_e                     last_cmd;
    logic [2:0]                   addr_pos;
    logic [`SATURN_ADDR_BITS-1:0] local_dp;
    logic [`SATURN_ADDR_BITS-1:0] dp_next;
    logic [`SATURN_ADDR_BITS-1:0] base_addr;
    logic [`SATURN_ADDR_BITS-1:0] offset;
    logic                         configured;
    logic                         active;
    logic                         last_addr;

    function automatic logic in_window(input logic [`SATURN_ADDR_BITS-1:0] ptr);
        in_window = configured && (ptr >= base_addr) && ((ptr - base_addr) < WORDS);
    endfunction

    always_comb begin
        dp_next = local_dp;
        dp_next[addr_pos * 4 +: 4] = i_bus_nibble;
    end

    assign last_addr    = (addr_pos == 3'(LAST_POS));
    assign offset       = local_dp - base_addr;
    assign o_bus_daisy  = configured;
    assign o_bus_active = active;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd   <= NONE;
            addr_pos   <= '0;
            local_dp   <= '0;
            base_addr  <= '0;
            configured <= 1'b0;
            active     <= 1'b0;
        end else if (i_bus_strobe) begin
            if (i_bus_is_data) begin
                case (last_cmd)
                    DP_READ, DP_WRITE: local_dp <= local_dp + 1'b1;
                    LOAD_DP: begin
                        local_dp <= dp_next;
                        addr_pos <= addr_pos + 3'd1;
                        if (last_addr) begin
                            last_cmd <= DP_READ;
                            active   <= in_window(dp_next);
                        end
                    end
                    CONFIGURE: begin
                        // only the first unconfigured device on the chain listens
                        if (i_bus_daisy && !configured) begin
                            base_addr[addr_pos * 4 +: 4] <= i_bus_nibble;
                            addr_pos                     <= addr_pos + 3'd1;
                            if (last_addr) begin
                                configured <= 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end else begin
                last_cmd <= bus_cmd_e'(i_bus_nibble);
                addr_pos <= '0;
                active   <= ((i_bus_nibble == DP_READ) || (i_bus_nibble == DP_WRITE))
                            && in_window(local_dp);
                if (i_bus_nibble == RESET) begin
                    base_addr  <= '0;
                    configured <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bus_strobe && i_bus_is_data && active) begin
            if (last_cmd == DP_WRITE) begin
                mem[offset[`SATURN_RAM_BITS-1:0]] <= i_bus_nibble;
            end
            if (last_cmd == DP_READ) begin
                o_bus_nibble_out <= mem[offset[`SATURN_RAM_BITS-1:0]];
            end
        end
    end

    active_needs_config: assert property (@(posedge i_clk) disable iff (i_reset)
        o_bus_active |-> configured)
        else $error("RAM active while unconfigured");

endmodule

`default_nettype wire

// ==== src/saturn_bus_top.sv ====
// ======================================================================
// top level of the nibble bus system
//   bus controller, system RAM and I/O register block,
//   daisy chain runs controller -> RAM -> I/O block
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_settings.svh"

module saturn_bus_top (
    input  wire                           i_clk,
    input  wire                           i_reset,
    input  wire                           i_req,
    input  var saturn_bus_pkg::host_op_e  i_op,
    input  wire  [`SATURN_ADDR_BITS-1:0]  i_addr,
    input  wire  [3:0]                    i_wdata,
    output logic                          o_ack,
    output logic [3:0]                    o_rdata,
    output logic [5:0]                    o_menu_height,
    output logic                          o_rom_mode
);

    logic       bus_strobe;
    logic       bus_is_data;
    logic [3:0] bus_nibble;
    logic       daisy_ctrl;
    logic       daisy_ram;
    logic [3:0] ram_nibble;
    logic       ram_active;
    logic [3:0] mmio_nibble;
    logic       mmio_active;

    saturn_bus_ctrl i_saturn_bus_ctrl (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_req         (i_req),
        .i_op          (i_op),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .o_ack         (o_ack),
        .o_rdata       (o_rdata),
        .o_bus_strobe  (bus_strobe),
        .o_bus_is_data (bus_is_data),
        .o_bus_nibble  (bus_nibble),
        .o_daisy       (daisy_ctrl),
        .i_ram_nibble  (ram_nibble),
        .i_ram_active  (ram_active),
        .i_mmio_nibble (mmio_nibble),
        .i_mmio_active (mmio_active)
    );

    // first on the chain, so the first configure lands here
    saturn_sysram i_saturn_sysram (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_bus_strobe     (bus_strobe),
        .i_bus_is_data    (bus_is_data),
        .i_bus_nibble     (bus_nibble),
        .i_bus_daisy      (daisy_ctrl),
        .o_bus_daisy      (daisy_ram),
        .o_bus_nibble_out (ram_nibble),
        .o_bus_active     (ram_active)
    );

    // end of the chain
    saturn_mmio i_saturn_mmio (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_bus_strobe     (bus_strobe),
        .i_bus_is_data    (bus_is_data),
        .i_bus_nibble     (bus_nibble),
        .i_bus_daisy      (daisy_ram),
        .o_bus_daisy      (),
        .o_bus_nibble_out (mmio_nibble),
        .o_bus_active     (mmio_active),
        .o_menu_height    (o_menu_height),
        .o_rom_mode       (o_rom_mode)
    );

endmodule

`default_nettype wire

// ==== verif/saturn_bus_tb.sv ====
// ======================================================================
// testbench for the nibble bus system
//   four-phase host driver, memory model of both device windows,
//   reference read function and a single compare task
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_settings.svh"

module saturn_bus_tb;
    import saturn_bus_pkg::*;

    localparam int unsigned RAM_WORDS   = 1 << `SATURN_RAM_BITS;
    localparam int unsigned IO_WORDS    = 1 << `SATURN_MMIO_BITS;
    localparam int unsigned ACK_TIMEOUT = 64;
    localparam logic [`SATURN_ADDR_BITS-1:0] RAM_BASE = 20'h80000;
    localparam logic [`SATURN_ADDR_BITS-1:0] IO_BASE  = 20'h00100;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         req;
    host_op_e                     op;
    logic [`SATURN_ADDR_BITS-1:0] addr;
    logic [3:0]                   wdata;
    logic                         ack;
    logic [3:0]                   rdata;
    logic [5:0]                   menu_height;
    logic                         rom_mode;

    // model of the bus system
    logic [`SATURN_ADDR_BITS-1:0] ram_base_m;
    logic [`SATURN_ADDR_BITS-1:0] io_base_m;
    int                           cfg_count;
    logic [3:0]                   ram_model [RAM_WORDS];
    logic [3:0]                   io_model [IO_WORDS];
    logic [31:0]                  rng;

    saturn_bus_top i_saturn_bus_top (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_req         (req),
        .i_op          (op),
        .i_addr        (addr),
        .i_wdata       (wdata),
        .o_ack         (ack),
        .o_rdata       (rdata),
        .o_menu_height (menu_height),
        .o_rom_mode    (rom_mode)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [3:0] fill_nibble(input logic [`SATURN_ADDR_BITS-1:0] a);
        return a[3:0] ^ {a[6:4], a[7]} ^ a[11:8] ^ a[15:12] ^ a[19:16];
    endfunction

    // first configure goes to the RAM and the second to the I/O block
    function automatic logic in_ram(input logic [`SATURN_ADDR_BITS-1:0] a);
        return (cfg_count >= 1) && (a >= ram_base_m) && ((a - ram_base_m) < RAM_WORDS);
    endfunction

    function automatic logic in_io(input logic [`SATURN_ADDR_BITS-1:0] a);
        return (cfg_count >= 2) && (a >= io_base_m) && ((a - io_base_m) < IO_WORDS);
    endfunction

    // expected read nibble is zero outside both windows
    function automatic logic [3:0] expected_read(input logic [`SATURN_ADDR_BITS-1:0] a);
        logic [`SATURN_ADDR_BITS-1:0] off;
        if (in_ram(a)) begin
            off = a - ram_base_m;
            return ram_model[off[`SATURN_RAM_BITS-1:0]];
        end else if (in_io(a)) begin
            off = a - io_base_m;
            return io_model[off[`SATURN_MMIO_BITS-1:0]];
        end
        return 4'h0;
    endfunction

    // menu height comes from offsets 0x28 and 0x29 and rom mode from bit 3 of 0x29
    function automatic logic [5:0] expected_menu_height();
        return {io_model[6'h29][1:0], io_model[6'h28]};
    endfunction

    function automatic logic expected_rom_mode();
        return io_model[6'h29][3];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // one four-phase transaction that returns o_rdata as seen with o_ack high
    task automatic run_host_op(input host_op_e op_in,
                               input logic [`SATURN_ADDR_BITS-1:0] addr_in,
                               input logic [3:0] wdata_in, output logic [3:0] rdata_out);
        int cycles;
        @(posedge clk);
        req   <= 1'b1;
        op    <= op_in;
        addr  <= addr_in;
        wdata <= wdata_in;
        cycles = 0;
        @(posedge clk);
        while ((ack !== 1'b1) && (cycles < ACK_TIMEOUT)) begin
            cycles++;
            @(posedge clk);
        end
        if (ack !== 1'b1) begin
            $display("timeout: ack did not rise after the request");
            $display("TEST FAILED");
            $fatal(1, "ack rise timeout");
        end
        rdata_out = rdata;
        req <= 1'b0;
        cycles = 0;
        @(posedge clk);
        while ((ack !== 1'b0) && (cycles < ACK_TIMEOUT)) begin
            cycles++;
            @(posedge clk);
        end
        if (ack !== 1'b0) begin
            $display("timeout: ack did not fall after the request was dropped");
            $display("TEST FAILED");
            $fatal(1, "ack fall timeout");
        end
    endtask

    task automatic host_configure(input logic [`SATURN_ADDR_BITS-1:0] base);
        logic [3:0] got;
        run_host_op(OP_CONFIGURE, base, 4'h0, got);
        // the daisy chain runs dry after two devices
        if (cfg_count == 0) begin
            ram_base_m = base;
        end else if (cfg_count == 1) begin
            io_base_m = base;
        end
        if (cfg_count < 2) begin
            cfg_count++;
        end
    endtask

    task automatic write_and_model(input logic [`SATURN_ADDR_BITS-1:0] a, input logic [3:0] d);
        logic [3:0]                   got;
        logic [`SATURN_ADDR_BITS-1:0] off;
        run_host_op(OP_WRITE, a, d, got);
        if (in_ram(a)) begin
            off = a - ram_base_m;
            ram_model[off[`SATURN_RAM_BITS-1:0]] = d;
        end else if (in_io(a)) begin
            off = a - io_base_m;
            io_model[off[`SATURN_MMIO_BITS-1:0]] = d;
        end
    endtask

    task automatic read_and_check(input string name, input logic [`SATURN_ADDR_BITS-1:0] a);
        logic [3:0] got;
        run_host_op(OP_READ, a, 4'h0, got);
        check_value(name, expected_read(a), got);
    endtask

    task automatic check_controls(input string name);
        check_value({name, " menu height"}, expected_menu_height(), menu_height);
        check_value({name, " rom mode"}, expected_rom_mode(), rom_mode);
    endtask

    initial begin
        logic [`SATURN_ADDR_BITS-1:0] a;
        reset <= 1'b1;
        req   <= 1'b0;
        op    <= OP_READ;
        addr  <= '0;
        wdata <= '0;
        rng        = 32'h654f;
        cfg_count  = 0;
        ram_base_m = '0;
        io_base_m  = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_model[i] = 4'h0;
        end
        for (int i = 0; i < IO_WORDS; i++) begin
            io_model[i] = 4'h0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // no device configured yet
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            read_and_check("unconfigured read", rng[19:0]);
        end
        check_controls("after reset");

        host_configure(RAM_BASE);
        host_configure(IO_BASE);

        // fill both windows so every later read has a known value
        for (int i = 0; i < RAM_WORDS; i++) begin
            a = RAM_BASE + i;
            write_and_model(a, fill_nibble(a));
        end
        for (int i = 0; i < IO_WORDS; i++) begin
            a = IO_BASE + i;
            write_and_model(a, fill_nibble(a));
        end
        read_and_check("ram fill", RAM_BASE + 20'd17);
        read_and_check("io fill", IO_BASE + 20'd3);
        check_controls("after fill");

        // RAM edges, then random write and read back
        rng = xorshift32(rng);
        write_and_model(RAM_BASE, rng[3:0]);
        write_and_model(RAM_BASE + RAM_WORDS - 1, rng[7:4]);
        read_and_check("ram first nibble", RAM_BASE);
        read_and_check("ram last nibble", RAM_BASE + RAM_WORDS - 1);
        for (int i = 0; i < 32; i++) begin
            rng = xorshift32(rng);
            a = RAM_BASE + rng[7:0];
            write_and_model(a, rng[11:8]);
            read_and_check("ram random", a);
        end

        // decoded I/O registers
        for (int i = 0; i < 6; i++) begin
            rng = xorshift32(rng);
            write_and_model(IO_BASE + 20'h28, rng[3:0]);
            check_controls("menu low write");
            write_and_model(IO_BASE + 20'h29, rng[7:4]);
            check_controls("menu high write");
        end
        for (int i = 0; i < IO_WORDS; i++) begin
            read_and_check("io readback", IO_BASE + i);
        end

        // just outside each window
        for (int i = 0; i < 4; i++) begin
            case (i)
                0: a = IO_BASE - 1;
                1: a = IO_BASE + IO_WORDS;
                2: a = RAM_BASE - 1;
                default: a = RAM_BASE + RAM_WORDS;
            endcase
            rng = xorshift32(rng);
            write_and_model(a, rng[3:0]);
            read_and_check("outside window", a);
        end
        check_controls("after outside writes");

        // a third configure finds no unconfigured device
        host_configure(20'h00000);
        for (int i = 0; i < RAM_WORDS; i++) begin
            read_and_check("ram after third configure", RAM_BASE + i);
        end
        for (int i = 0; i < IO_WORDS; i++) begin
            read_and_check("io after third configure", IO_BASE + i);
        end
        check_controls("after third configure");

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
src/saturn_bus_pkg.sv
src/saturn_bus_ctrl.sv
src/saturn_mmio.sv
src/saturn_sysram.sv
src/saturn_bus_top.sv
verif/saturn_bus_tb.sv
